// ==== flist.f ====
rtl/mipsPkg.sv
rtl/fetchUnit.sv
rtl/regFile.sv
rtl/instDecode.sv
rtl/executeStage.sv
rtl/resultStage.sv
rtl/mipsCore.sv
test/tbMipsCore.sv

// ==== rtl/executeStage.sv ====
module executeStage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             freeze,
  input  logic             regWrite,
  input  logic             memRead,
  input  logic             memWrite,
  input  logic             aluSrc,
  input  logic             regDst,
  input  mipsPkg::aluCtrlT aluOp,
  input  mipsPkg::regIdxT  exRs,
  input  mipsPkg::regIdxT  exRt,
  input  mipsPkg::regIdxT  exRd,
  input  mipsPkg::wordT    exA,
  input  mipsPkg::wordT    exB,
  input  mipsPkg::wordT    exImm,
  input  logic             wbWrite,
  input  mipsPkg::regIdxT  wbDest,
  input  mipsPkg::wordT    wbData,
  output mipsPkg::wordT    exResult,
  output mipsPkg::regIdxT  exDest,
  output logic             exRegWrite,
  output logic             exMemRead,
  output logic             memMemRead,
  output logic             memMemWrite,
  output logic             memRegWrite,
  output mipsPkg::wordT    memAddr,
  output mipsPkg::wordT    memWdata,
  output mipsPkg::regIdxT  memDest
);

  mipsPkg::wordT fwdA, fwdB, opB;
  mipsPkg::aluCtrlT aluCtrl;
  logic memHitA, memHitB;

  // EX/MEM wins over MEM/WB, $0 never forwards
  assign memHitA = memRegWrite && memDest != '0 && memDest == exRs;
  assign memHitB = memRegWrite && memDest != '0 && memDest == exRt;
  assign fwdA = memHitA ? memAddr :
                (wbWrite && wbDest != '0 && wbDest == exRs) ? wbData : exA;
  assign fwdB = memHitB ? memAddr :
                (wbWrite && wbDest != '0 && wbDest == exRt) ? wbData : exB;
  assign opB  = aluSrc ? exImm : fwdB;

  always_comb begin
    aluCtrl = aluOp;
    if (regDst) begin         // r-type, decode by funct
      case (mipsPkg::functT'(exImm[5:0]))
        mipsPkg::FN_SUB: aluCtrl = mipsPkg::ALU_SUB;
        mipsPkg::FN_AND: aluCtrl = mipsPkg::ALU_AND;
        mipsPkg::FN_OR:  aluCtrl = mipsPkg::ALU_OR;
        mipsPkg::FN_SLT: aluCtrl = mipsPkg::ALU_SLT;
        mipsPkg::FN_ADD: aluCtrl = mipsPkg::ALU_ADD;
        default:         aluCtrl = mipsPkg::ALU_ADD;
      endcase
    end
  end

  always_comb begin
    case (aluCtrl)
      mipsPkg::ALU_SUB: exResult = fwdA - opB;
      mipsPkg::ALU_AND: exResult = fwdA & opB;
      mipsPkg::ALU_OR:  exResult = fwdA | opB;
      mipsPkg::ALU_SLT: exResult = {31'd0, $signed(fwdA) < $signed(opB)};
      default:          exResult = fwdA + opB;
    endcase
  end

  assign exDest     = regDst ? exRd : exRt;
  assign exRegWrite = regWrite;
  assign exMemRead  = memRead;  // for the load-use check in decode

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {memMemRead, memMemWrite, memRegWrite} <= '0;
    end else if (!freeze) begin
      {memMemRead, memMemWrite, memRegWrite} <= {memRead, memWrite, regWrite};
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      memAddr  <= exResult;
      memWdata <= fwdB;      // store data after forwarding
      memDest  <= exDest;
    end
  end

endmodule

// ==== rtl/fetchUnit.sv ====
module fetchUnit #(
  parameter mipsPkg::wordT resetPc = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          freeze,
  input  logic          pcHold,
  input  logic          redirect,
  input  mipsPkg::wordT redirectPc,
  input  mipsPkg::wordT iRdata,
  output logic [29:0]   iAddr,
  output mipsPkg::wordT idInst,
  output mipsPkg::wordT idPcPlus4
);

  mipsPkg::wordT pc, pcPlus4, nextPc;

  assign iAddr   = pc[31:2];  // word address to the icache
  assign pcPlus4 = pc + 32'd4;
  assign nextPc  = redirect ? redirectPc : pcPlus4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= resetPc;
    end else if (!freeze && !pcHold) begin
      pc <= nextPc;
    end
  end

  // IF/ID instruction, zero is a nop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idInst <= '0;
    end else if (!freeze) begin
      if (redirect) begin
        idInst <= '0;     // squash the wrong-path fetch
      end else if (!pcHold) begin
        idInst <= iRdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze && !pcHold) begin
      idPcPlus4 <= pcPlus4;
    end
  end

endmodule

// ==== rtl/instDecode.sv ====
module instDecode (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             freeze,
  input  mipsPkg::wordT    idInst,
  input  mipsPkg::wordT    idPcPlus4,
  input  mipsPkg::wordT    rsData,
  input  mipsPkg::wordT    rtData,
  input  mipsPkg::wordT    exResult,
  input  mipsPkg::regIdxT  exDest,
  input  logic             exRegWrite,
  input  logic             exMemRead,
  output mipsPkg::regIdxT  rs,
  output mipsPkg::regIdxT  rt,
  output logic             pcHold,
  output logic             redirect,
  output mipsPkg::wordT    redirectPc,
  output logic             regWrite,
  output logic             memRead,
  output logic             memWrite,
  output logic             aluSrc,
  output logic             regDst,
  output mipsPkg::aluCtrlT aluOp,
  output mipsPkg::regIdxT  exRs,
  output mipsPkg::regIdxT  exRt,
  output mipsPkg::regIdxT  exRd,
  output mipsPkg::wordT    exA,
  output mipsPkg::wordT    exB,
  output mipsPkg::wordT    exImm
);

  mipsPkg::opcodeT opcode;
  mipsPkg::wordT imm, cmpA, cmpB;
  mipsPkg::regIdxT memDestQ;
  logic decRegWrite, decMemRead, decMemWrite, decAluSrc, decRegDst, isBeq, isJump;
  logic memWriteQ, loadUse, branchStall, hazard;

  assign opcode = idInst[31:26];
  assign rs     = idInst[25:21];
  assign rt     = idInst[20:16];
  assign imm    = {{16{idInst[15]}}, idInst[15:0]};

  always_comb begin
    {decRegWrite, decMemRead, decMemWrite, decAluSrc, decRegDst} = '0;
    {isBeq, isJump} = '0;
    case (opcode)
      mipsPkg::OP_RTYPE: {decRegWrite, decRegDst} = 2'b11; // funct picks the op later
      mipsPkg::OP_ADDI:  {decRegWrite, decAluSrc} = 2'b11;
      mipsPkg::OP_LW:    {decRegWrite, decMemRead, decAluSrc} = 3'b111;
      mipsPkg::OP_SW:    {decMemWrite, decAluSrc} = 2'b11;
      mipsPkg::OP_BEQ:   isBeq = 1'b1;
      mipsPkg::OP_J:     isJump = 1'b1;
      default:           ;
    endcase
  end

  // EX result feeds the compare directly
  assign cmpA = (exRegWrite && exDest != '0 && exDest == rs) ? exResult : rsData;
  assign cmpB = (exRegWrite && exDest != '0 && exDest == rt) ? exResult : rtData;

  assign loadUse     = exMemRead && exDest != '0 && (exDest == rs || exDest == rt);
  // no path from MEM into the compare, so wait until it reaches writeback
  assign branchStall = isBeq && memWriteQ && memDestQ != '0 &&
                       (memDestQ == rs || memDestQ == rt);
  assign hazard      = loadUse || branchStall;
  assign pcHold      = hazard;
  assign redirect    = !hazard && (isJump || (isBeq && cmpA == cmpB));
  assign redirectPc  = isJump ? {idPcPlus4[31:28], idInst[25:0], 2'b00}
                              : idPcPlus4 + {imm[29:0], 2'b00};

  // copy of the EX/MEM destination for the branch check
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memWriteQ <= 1'b0;
    end else if (!freeze) begin
      memWriteQ <= exRegWrite;
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      memDestQ <= exDest;
      {exRs, exRt, exRd} <= {rs, rt, idInst[15:11]};
      {exA, exB, exImm} <= {rsData, rtData, imm};
    end
  end

  // ID/EX control, a hazard inserts a bubble
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {regWrite, memRead, memWrite, aluSrc, regDst} <= '0;
      aluOp <= mipsPkg::ALU_ADD;
    end else if (!freeze) begin
      if (hazard) begin
        {regWrite, memRead, memWrite, aluSrc, regDst} <= '0;
      end else begin
        {regWrite, memRead, memWrite} <= {decRegWrite, decMemRead, decMemWrite};
        {aluSrc, regDst} <= {decAluSrc, decRegDst};
      end
      aluOp <= mipsPkg::ALU_ADD; // i-type ops all add
    end
  end

endmodule

// ==== rtl/mipsCore.sv ====
module mipsCore #(
  parameter mipsPkg::wordT resetPc = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst_n,
  output logic          iRen,
  output logic [29:0]   iAddr,
  input  mipsPkg::wordT iRdata,
  input  logic          iStall,
  output logic          dRen,
  output logic          dWen,
  output logic [29:0]   dAddr,
  output mipsPkg::wordT dWdata,
  input  mipsPkg::wordT dRdata,
  input  logic          dStall
);

  logic freeze, pcHold, redirect;
  logic regWrite, memRead, memWrite, aluSrc, regDst;
  logic exRegWrite, exMemRead, memMemRead, memMemWrite, memRegWrite, wbWrite;
  mipsPkg::aluCtrlT aluOp;
  mipsPkg::regIdxT rs, rt, exRs, exRt, exRd, exDest, memDest, wbDest;
  mipsPkg::wordT redirectPc, idInst, idPcPlus4, rsData, rtData;
  mipsPkg::wordT exA, exB, exImm, exResult, memAddr, memWdata, wbData;

  assign freeze = iStall | dStall; // any cache stall holds the whole pipe
  assign iRen   = 1'b1;

  // a store is offered only while fetch is not stalling, so it is taken once
  assign dWen   = memMemWrite & ~iStall;
  assign dRen   = memMemRead;
  assign dAddr  = memAddr[31:2];
  assign dWdata = memWdata;

  fetchUnit #(.resetPc(resetPc)) uFetch (
    .clk(clk), .rst_n(rst_n), .freeze(freeze), .pcHold(pcHold),
    .redirect(redirect), .redirectPc(redirectPc), .iRdata(iRdata),
    .iAddr(iAddr), .idInst(idInst), .idPcPlus4(idPcPlus4)
  );

  regFile uRegs (
    .clk(clk), .rst_n(rst_n), .freeze(freeze), .rs(rs), .rt(rt),
    .wbWrite(wbWrite), .wbDest(wbDest), .wbData(wbData),
    .rsData(rsData), .rtData(rtData)
  );

  instDecode uDecode (
    .clk(clk), .rst_n(rst_n), .freeze(freeze), .idInst(idInst), .idPcPlus4(idPcPlus4),
    .rsData(rsData), .rtData(rtData), .exResult(exResult), .exDest(exDest),
    .exRegWrite(exRegWrite), .exMemRead(exMemRead), .rs(rs), .rt(rt),
    .pcHold(pcHold), .redirect(redirect), .redirectPc(redirectPc),
    .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite), .aluSrc(aluSrc),
    .regDst(regDst), .aluOp(aluOp), .exRs(exRs), .exRt(exRt), .exRd(exRd),
    .exA(exA), .exB(exB), .exImm(exImm)
  );

  executeStage uExecute (
    .clk(clk), .rst_n(rst_n), .freeze(freeze), .regWrite(regWrite), .memRead(memRead),
    .memWrite(memWrite), .aluSrc(aluSrc), .regDst(regDst), .aluOp(aluOp),
    .exRs(exRs), .exRt(exRt), .exRd(exRd), .exA(exA), .exB(exB), .exImm(exImm),
    .wbWrite(wbWrite), .wbDest(wbDest), .wbData(wbData), .exResult(exResult),
    .exDest(exDest), .exRegWrite(exRegWrite), .exMemRead(exMemRead),
    .memMemRead(memMemRead), .memMemWrite(memMemWrite), .memRegWrite(memRegWrite),
    .memAddr(memAddr), .memWdata(memWdata), .memDest(memDest)
  );

  resultStage uResult (
    .clk(clk), .rst_n(rst_n), .freeze(freeze), .memMemRead(memMemRead),
    .memRegWrite(memRegWrite), .memAddr(memAddr), .memDest(memDest), .dRdata(dRdata),
    .wbWrite(wbWrite), .wbDest(wbDest), .wbData(wbData)
  );

endmodule

// ==== rtl/mipsPkg.sv ====
package mipsPkg;

  typedef logic [31:0] wordT;    // data or address word
  typedef logic [4:0]  regIdxT;  // register number
  typedef logic [5:0]  opcodeT;  // instruction bits 31..26
  typedef logic [5:0]  functT;   // r-type bits 5..0
  typedef logic [2:0]  aluCtrlT; // alu operation select

  // opcodes of the supported instructions
  localparam opcodeT OP_RTYPE = 6'b000000;
  localparam opcodeT OP_ADDI  = 6'b001000;
  localparam opcodeT OP_LW    = 6'b100011;
  localparam opcodeT OP_SW    = 6'b101011;
  localparam opcodeT OP_BEQ   = 6'b000100;
  localparam opcodeT OP_J     = 6'b000010;

  // r-type funct codes
  localparam functT FN_ADD = 6'b100000;
  localparam functT FN_SUB = 6'b100010;
  localparam functT FN_AND = 6'b100100;
  localparam functT FN_OR  = 6'b100101;
  localparam functT FN_SLT = 6'b101010;

  // alu operations
  localparam aluCtrlT ALU_ADD = 3'd0;
  localparam aluCtrlT ALU_SUB = 3'd1;
  localparam aluCtrlT ALU_AND = 3'd2;
  localparam aluCtrlT ALU_OR  = 3'd3;
  localparam aluCtrlT ALU_SLT = 3'd4; // signed compare

endpackage

// ==== rtl/regFile.sv ====
module regFile (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            freeze,
  input  mipsPkg::regIdxT rs,
  input  mipsPkg::regIdxT rt,
  input  logic            wbWrite,
  input  mipsPkg::regIdxT wbDest,
  input  mipsPkg::wordT   wbData,
  output mipsPkg::wordT   rsData,
  output mipsPkg::wordT   rtData
);

  mipsPkg::wordT regs [1:31]; // $0 has no storage
  logic doWrite;

  assign doWrite = wbWrite && (wbDest != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (doWrite && !freeze) begin
      regs[wbDest] <= wbData;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign rsData = (rs == '0) ? '0 : (doWrite && wbDest == rs) ? wbData : regs[rs];
  assign rtData = (rt == '0) ? '0 : (doWrite && wbDest == rt) ? wbData : regs[rt];

endmodule

// ==== rtl/resultStage.sv ====
module resultStage (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            freeze,
  input  logic            memMemRead,
  input  logic            memRegWrite,
  input  mipsPkg::wordT   memAddr,
  input  mipsPkg::regIdxT memDest,
  input  mipsPkg::wordT   dRdata,
  output logic            wbWrite,
  output mipsPkg::regIdxT wbDest,
  output mipsPkg::wordT   wbData
);

  mipsPkg::wordT wbAlu, wbLoad;
  logic wbIsLoad;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {wbWrite, wbIsLoad} <= '0;
    end else if (!freeze) begin
      {wbWrite, wbIsLoad} <= {memRegWrite, memMemRead};
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      wbDest <= memDest;
      wbAlu  <= memAddr;
      wbLoad <= dRdata;  // valid here since dStall is low
    end
  end

  assign wbData = wbIsLoad ? wbLoad : wbAlu;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns -f flist.f --top-module tbMipsCore \
  --Mdir obj_dir -o simMips > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simMips > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && echo "result PASS" || { echo "result FAIL"; exit 1; }

// ==== test/mipsPatterns.txt ====
// words 00..3f hold the program, one instruction word per line
// from @40 the store count, then byte address and data of each store in order
20010007 // addi $1,$0,7
2002FFFD // addi $2,$0,-3
00221820 // add  $3,$1,$2
AC030000 // sw   $3,0($0)
00222022 // sub  $4,$1,$2
AC040004 // sw   $4,4($0)
00222824 // and  $5,$1,$2
AC050008 // sw   $5,8($0)
00223025 // or   $6,$1,$2
AC06000C // sw   $6,12($0)
0041382A // slt  $7,$2,$1
AC070010 // sw   $7,16($0)
8C080000 // lw   $8,0($0)
01014820 // add  $9,$8,$1 right after the load
AC090014 // sw   $9,20($0)
10210001 // beq  $1,$1 taken
AC010018 // sw   $1,24($0) skipped
10220001 // beq  $1,$2 not taken
AC02001C // sw   $2,28($0)
202AFFF9 // addi $10,$1,-7
11400001 // beq  $10,$0 on the value just computed
AC010020 // sw   $1,32($0) skipped
08000018 // j    24
AC010024 // sw   $1,36($0) skipped
0022382A // slt  $7,$1,$2
AC070028 // sw   $7,40($0)
0800001A // j    26 forever
@40
00000008
00000000 00000004
00000004 0000000A
00000008 00000005
0000000C FFFFFFFF
00000010 00000001
00000014 0000000B
0000001C FFFFFFFD
00000028 00000000

// ==== test/tbMipsCore.sv ====
module tbMipsCore;

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;
  localparam int EXP_BASE      = 64;   // pattern slot holding the store count
  localparam int STORE_TIMEOUT = 3000; // cycles allowed for the whole store list
  localparam int TAIL_CYCLES   = 50;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic iStall = 1'b0;
  logic dStall = 1'b0;
  logic iRen, dRen, dWen;
  logic [29:0] iAddr, dAddr;
  logic [31:0] iRdata, dRdata, dWdata;

  logic [31:0] patterns [0:127] = '{default: '0};
  logic [31:0] dataMem [0:63] = '{default: '0};
  int storeCount;
  int storeIdx = 0;

  string storeNames [0:7] = '{"add forwarding", "sub", "and", "or", "slt",
                              "load-use", "beq not taken", "jump target slt"};

  mipsCore #(.resetPc(RESET_PC)) dut (
    .clk(clk), .rst_n(rst_n), .iRen(iRen), .iAddr(iAddr), .iRdata(iRdata),
    .iStall(iStall), .dRen(dRen), .dWen(dWen), .dAddr(dAddr), .dWdata(dWdata),
    .dRdata(dRdata), .dStall(dStall)
  );

  always #5 clk = ~clk;

  // junk on the read buses while stalled or not enabled
  assign iRdata = (iStall || !iRen) ? {2'b11, iAddr} :
                  (iAddr < 30'd64) ? patterns[iAddr[5:0]] : 32'h0;
  assign dRdata = (dStall || !dRen) ? {2'b10, dAddr} : dataMem[dAddr[5:0]];

  // one-cycle stalls with a 1 in 4 chance each
  always @(posedge clk) begin
    if (!rst_n) begin
      iStall <= 1'b0;
      dStall <= 1'b0;
    end else begin
      iStall <= !iStall && ($urandom % 4 == 0);
      dStall <= !dStall && ($urandom % 4 == 0);
    end
  end

  function automatic string testName(int idx);
    if (idx < 8) begin
      return storeNames[idx[2:0]];
    end
    return "extra store";
  endfunction

  task automatic stopWithFailure();
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
    logic [6:0] slot;
    logic [31:0] expAddr;
    logic [31:0] expData;
    assert (storeIdx < storeCount) else begin
      $display("store of %h to address %h came after the last expected store", data, addr);
      stopWithFailure();
    end
    slot = 7'(EXP_BASE + 1 + 2 * storeIdx);
    expAddr = patterns[slot];
    expData = patterns[slot + 7'd1];
    assert (addr == expAddr) else begin
      $display("[ERROR] %s address expected %h actual %h",
               testName(storeIdx), expAddr, addr);
      stopWithFailure();
    end
    assert (data == expData) else begin
      $display("[ERROR] %s data expected %h actual %h",
               testName(storeIdx), expData, data);
      stopWithFailure();
    end
  endtask

  // data cache write port takes a store on an edge without dStall
  always @(posedge clk) begin
    if (rst_n) begin
      assert (!(dRen && dWen)) else begin
        $display("data cache read and write requested in the same cycle");
        stopWithFailure();
      end
      if (dWen && !dStall) begin
        checkStore({dAddr, 2'b00}, dWdata);
        dataMem[dAddr[5:0]] <= dWdata;
        storeIdx <= storeIdx + 1;
      end
    end
  end

  initial begin
    int waitCycles;
    void'($urandom(32'h2a975661));
    $readmemh("test/mipsPatterns.txt", patterns);
    storeCount = patterns[EXP_BASE];
    repeat (16) @(posedge clk);
    assert (iAddr == RESET_PC[31:2]) else begin
      $display("[ERROR] reset iAddr expected %h actual %h", RESET_PC[31:2], iAddr);
      stopWithFailure();
    end
    assert (!dRen && !dWen) else begin
      $display("data cache request active during reset");
      stopWithFailure();
    end
    rst_n <= 1'b1;

    waitCycles = 0;
    while (storeIdx < storeCount && waitCycles < STORE_TIMEOUT) begin
      @(posedge clk);
      waitCycles++;
    end
    assert (storeIdx >= storeCount) else begin
      $display("timed out waiting for store %0d of %0d", storeIdx + 1, storeCount);
      stopWithFailure();
    end

    // the program now spins on its last jump and writes nothing more
    waitCycles = 0;
    while (waitCycles < TAIL_CYCLES) begin
      @(posedge clk);
      waitCycles++;
    end

    $display("sim passed");
    $finish;
  end

endmodule
